//--- decodePkg.sv
`default_nettype none

package decodePkg;

    // ========================================
    // Field types
    // ========================================
    typedef logic [47:0] instrT;
    typedef logic [4:0]  regIdxT;
    typedef logic [4:0]  idTagT;
    typedef logic [63:0] constT;
    typedef logic [7:0]  laneMaskT;
    typedef logic [2:0]  instrLenT;
    typedef logic [1:0]  memSizeT;
    typedef logic [2:0]  creditT;
    typedef logic [5:0]  opcodeT;
    typedef logic [5:0]  functT;

    // Entries in the instruction queue
    localparam int QUEUE_DEPTH = 4;

    localparam memSizeT MEM_BYTE  = 2'd0;
    localparam memSizeT MEM_WYDE  = 2'd1;
    localparam memSizeT MEM_TETRA = 2'd2;
    localparam memSizeT MEM_OCTA  = 2'd3;

    // ========================================
    // Opcodes and functs
    // ========================================
    localparam opcodeT BRK = 6'd0, R2 = 6'd2, ADDI = 6'd4;
    localparam opcodeT MULI = 6'd6, ANDI = 6'd8, ORI = 6'd9;
    localparam opcodeT FLOAT = 6'd15, LB = 6'd19, SB = 6'd21;
    localparam opcodeT MEMNDX = 6'd22, JAL = 6'd24, LX = 6'd32;
    localparam opcodeT SX = 6'd36, JMP = 6'd40, CALL = 6'd41;
    localparam opcodeT RET = 6'd42, CAS = 6'd44, AMO = 6'd46;
    localparam opcodeT BCC = 6'd48, BEQI = 6'd50, DIVI = 6'd62;

    // R2 functs
    localparam functT R1 = 6'd1, ADD = 6'd4, SUB = 6'd5;
    localparam functT AND = 6'd8, OR = 6'd9, SHIFTR = 6'd47;
    localparam functT RTI = 6'd50, MUL = 6'd58, DIVMOD = 6'd62;

    // R1 subfunctions
    localparam logic [4:0] MEMDB = 5'd16, MEMSB = 5'd17, SYNC = 5'd18;

    // Indexed memory functs
    localparam functT LBX = 6'd0, LWX = 6'd4, LWRX = 6'd6;
    localparam functT SBX = 6'd16, SWX = 6'd20, SWCX = 6'd22;
    localparam functT CASX = 6'd24;

    localparam functT FADD = 6'd4, FSYNC = 6'd54;

    // ========================================
    // Decoded records
    // ========================================
    typedef struct packed {
        logic    isMem, isMemNdx, isLoad, isVolatileLoad, isStore, isRmw;
        memSizeT memSize;
        logic    isAcquire, isRelease, isMemDb, isMemSb;
    } memInfoS;

    typedef struct packed {
        logic isAlu, isAlu0, isFpu, isFlowCtrl, isBranch, branchTaken;
        logic isJmp, isSync, isFSync, isOddball, canExcept;
    } unitInfoS;

    typedef struct packed {
        constT    constVal;
        instrLenT len;
        logic     hasConst, regWrite, preload;
        laneMaskT writeLanes;
    } operandInfoS;

    typedef struct packed {
        memInfoS     memInfo;
        unitInfoS    unitInfo;
        operandInfoS operandInfo;
        idTagT       id;
    } decodedInstrS;

    // Field extraction
    function automatic opcodeT getOpcode(instrT instr);
        return instr[5:0];
    endfunction

    function automatic logic [1:0] getLenField(instrT instr);
        return instr[7:6];
    endfunction

    function automatic functT getFunct(instrT instr);
        return instr[31:26];
    endfunction

    function automatic logic [4:0] getSubFn(instrT instr);
        return instr[22:18];
    endfunction

    // Funct field only meaningful in the 4-byte form
    function automatic logic hasFunct(instrT instr);
        return getLenField(instr) == 2'b00;
    endfunction

endpackage

`default_nettype wire

//--- memClassify.sv
`default_nettype none

module memClassify
(
    input  decodePkg::instrT   instr_i,
    output decodePkg::memInfoS memInfo_o
);

    decodePkg::opcodeT  op;
    decodePkg::functT   fn;
    decodePkg::memSizeT size;
    logic ndxFn;
    logic r1Fn;
    logic ordered;
    logic isLbx, isLwx, isLwrx, isSbx, isSwx, isSwcx, isCasx;

    assign op = decodePkg::getOpcode(instr_i);
    assign fn = decodePkg::getFunct(instr_i);

    // Indexed forms
    assign ndxFn  = op == decodePkg::MEMNDX && decodePkg::hasFunct(instr_i);
    assign isLbx  = ndxFn && fn == decodePkg::LBX;
    assign isLwx  = ndxFn && fn == decodePkg::LWX;
    assign isLwrx = ndxFn && fn == decodePkg::LWRX;
    assign isSbx  = ndxFn && fn == decodePkg::SBX;
    assign isSwx  = ndxFn && fn == decodePkg::SWX;
    assign isSwcx = ndxFn && fn == decodePkg::SWCX;
    assign isCasx = ndxFn && fn == decodePkg::CASX;

    assign r1Fn = op == decodePkg::R2 && decodePkg::hasFunct(instr_i) && fn == decodePkg::R1;

    // Only AMO and the reserved indexed pair carry ordering bits
    assign ordered = op == decodePkg::AMO || isLwrx || isSwcx;

    // ========================================
    // Access size
    // ========================================
    always_comb
    begin
        case (op)
            decodePkg::LB, decodePkg::SB:
                size = decodePkg::MEM_BYTE;
            decodePkg::LX, decodePkg::SX:
                casez (instr_i[20:18])
                    3'b100:  size = decodePkg::MEM_OCTA;
                    3'b?10:  size = decodePkg::MEM_TETRA;
                    3'b??1:  size = decodePkg::MEM_WYDE;
                    default: size = decodePkg::MEM_OCTA;
                endcase
            decodePkg::AMO:
                case (instr_i[23:21])
                    3'd0:    size = decodePkg::MEM_BYTE;
                    3'd1:    size = decodePkg::MEM_WYDE;
                    3'd2:    size = decodePkg::MEM_TETRA;
                    default: size = decodePkg::MEM_OCTA;
                endcase
            default:
                size = (isLbx || isSbx) ? decodePkg::MEM_BYTE : decodePkg::MEM_OCTA;
        endcase
    end

    always_comb
    begin
        memInfo_o.isMem = op inside {decodePkg::LB, decodePkg::LX, decodePkg::SB,
            decodePkg::SX, decodePkg::CAS, decodePkg::AMO, decodePkg::MEMNDX};
        memInfo_o.isMemNdx       = op == decodePkg::MEMNDX;
        memInfo_o.isLoad         = op inside {decodePkg::LB, decodePkg::LX}
                                   || isLbx || isLwx || isLwrx;
        memInfo_o.isVolatileLoad = isLwrx;
        memInfo_o.isStore = op inside {decodePkg::SB, decodePkg::SX, decodePkg::CAS,
            decodePkg::AMO} || isSbx || isSwx || isSwcx || isCasx;
        memInfo_o.isRmw     = op inside {decodePkg::CAS, decodePkg::AMO} || isCasx;
        memInfo_o.memSize   = size;
        memInfo_o.isAcquire = ordered && instr_i[25];
        memInfo_o.isRelease = ordered && instr_i[24];
        memInfo_o.isMemDb   = r1Fn && decodePkg::getSubFn(instr_i) == decodePkg::MEMDB;
        memInfo_o.isMemSb   = r1Fn && decodePkg::getSubFn(instr_i) == decodePkg::MEMSB;
    end

endmodule

`default_nettype wire

//--- unitClassify.sv
`default_nettype none

module unitClassify
(
    input  decodePkg::instrT    instr_i,
    input  logic                predictTaken_i,
    input  logic                isMem_i,
    output decodePkg::unitInfoS unitInfo_o
);

    decodePkg::opcodeT op;
    decodePkg::functT  fn;
    logic r2Fn;
    logic floatFn;
    logic isRti;
    logic isBranch;

    assign op = decodePkg::getOpcode(instr_i);
    assign fn = decodePkg::getFunct(instr_i);

    // Funct decodes, base length only
    assign r2Fn    = op == decodePkg::R2 && decodePkg::hasFunct(instr_i);
    assign floatFn = op == decodePkg::FLOAT && decodePkg::hasFunct(instr_i);
    assign isRti   = r2Fn && fn == decodePkg::RTI;

    // Predictable branches
    assign isBranch = op inside {decodePkg::BCC, decodePkg::BEQI};

    // ========================================
    // Unit and control flags
    // ========================================
    always_comb
    begin
        unitInfo_o.isAlu = !(isRti || op inside {decodePkg::BRK, decodePkg::BCC,
            decodePkg::BEQI, decodePkg::JAL, decodePkg::JMP, decodePkg::CALL,
            decodePkg::RET, decodePkg::FLOAT});
        // Long latency ops go to unit 0 only
        unitInfo_o.isAlu0 = (r2Fn && fn inside {decodePkg::R1, decodePkg::SHIFTR,
            decodePkg::MUL, decodePkg::DIVMOD})
            || op inside {decodePkg::MEMNDX, decodePkg::MULI, decodePkg::DIVI};
        unitInfo_o.isFpu = op == decodePkg::FLOAT;
        unitInfo_o.isFlowCtrl = isRti || op inside {decodePkg::BRK, decodePkg::BCC,
            decodePkg::BEQI, decodePkg::JAL, decodePkg::JMP, decodePkg::CALL,
            decodePkg::RET};
        unitInfo_o.isBranch    = isBranch;
        unitInfo_o.branchTaken = isBranch && predictTaken_i;
        unitInfo_o.isJmp       = op == decodePkg::JMP && !instr_i[7];
        unitInfo_o.isSync = (r2Fn && fn == decodePkg::R1
            && decodePkg::getSubFn(instr_i) == decodePkg::SYNC)
            || op == decodePkg::BRK || isRti;
        unitInfo_o.isFSync   = floatFn && fn == decodePkg::FSYNC;
        unitInfo_o.isOddball = op inside {decodePkg::BRK, decodePkg::FLOAT} || isRti;
        // Memory ops fall through to isMem_i, loads and stores alike
        unitInfo_o.canExcept = (floatFn && fn == decodePkg::FADD)
            || op inside {decodePkg::ADDI, decodePkg::MULI, decodePkg::DIVI,
                decodePkg::BCC, decodePkg::BEQI}
            || (r2Fn && fn inside {decodePkg::ADD, decodePkg::SUB, decodePkg::MUL,
                decodePkg::DIVMOD, decodePkg::RTI})
            || isMem_i;
    end

endmodule

`default_nettype wire

//--- operandDecode.sv
`default_nettype none

module operandDecode
(
    input  decodePkg::instrT       instr_i,
    input  decodePkg::regIdxT      destReg_i,
    input  logic                   isLoad_i,
    output decodePkg::operandInfoS operandInfo_o
);

    decodePkg::opcodeT op;
    decodePkg::functT  fn;
    logic [1:0] lenField;
    logic r2Fn;
    logic ndxFn;
    logic writer;

    assign op       = decodePkg::getOpcode(instr_i);
    assign fn       = decodePkg::getFunct(instr_i);
    assign lenField = decodePkg::getLenField(instr_i);
    assign r2Fn     = op == decodePkg::R2 && decodePkg::hasFunct(instr_i);
    assign ndxFn    = op == decodePkg::MEMNDX && decodePkg::hasFunct(instr_i);

    // Ops that produce a register result
    assign writer = (r2Fn && fn inside {decodePkg::R1, decodePkg::ADD, decodePkg::SUB,
            decodePkg::AND, decodePkg::OR, decodePkg::MUL, decodePkg::DIVMOD,
            decodePkg::SHIFTR})
        || (ndxFn && fn inside {decodePkg::LBX, decodePkg::LWX, decodePkg::LWRX,
            decodePkg::CASX})
        || op inside {decodePkg::ADDI, decodePkg::ANDI, decodePkg::ORI, decodePkg::MULI,
            decodePkg::DIVI, decodePkg::JAL, decodePkg::CALL, decodePkg::RET,
            decodePkg::LB, decodePkg::LX, decodePkg::CAS, decodePkg::AMO};

    always_comb
    begin
        case (lenField)
            2'b00:   operandInfo_o.len = 3'd4;
            2'b01:   operandInfo_o.len = 3'd6;
            default: operandInfo_o.len = 3'd2;
        endcase

        // 30-bit constant in the 6-byte form, 14-bit otherwise
        if (lenField == 2'b01)
            operandInfo_o.constVal = {{34{instr_i[47]}}, instr_i[47:18]};
        else
            operandInfo_o.constVal = {{50{instr_i[31]}}, instr_i[31:18]};

        operandInfo_o.hasConst = op inside {decodePkg::ADDI, decodePkg::ANDI,
            decodePkg::ORI, decodePkg::MULI, decodePkg::DIVI, decodePkg::LB,
            decodePkg::LX, decodePkg::SB, decodePkg::SX, decodePkg::CAS,
            decodePkg::JAL, decodePkg::CALL, decodePkg::RET};

        // r0 is never written
        operandInfo_o.regWrite = destReg_i != '0 && writer;
        operandInfo_o.preload  = isLoad_i && destReg_i == '0;

        operandInfo_o.writeLanes = 8'hFF;
        if (r2Fn && fn inside {decodePkg::ADD, decodePkg::SUB, decodePkg::AND,
            decodePkg::OR, decodePkg::MUL, decodePkg::DIVMOD})
        begin
            case (instr_i[25:23])
                3'b000:  operandInfo_o.writeLanes = 8'h01;
                3'b001:  operandInfo_o.writeLanes = 8'h03;
                3'b010:  operandInfo_o.writeLanes = 8'h0F;
                default: operandInfo_o.writeLanes = 8'hFF;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- creditCounter.sv
`default_nettype none

module creditCounter
(
    input  logic clk,
    input  logic rstN_i,
    input  logic take_i,
    input  logic return_i,
    output logic hasCredit_o
);

    // Free entries in the instruction queue
    decodePkg::creditT count;

    always_ff @(posedge clk)
    begin
        if (!rstN_i)
        begin
            count <= decodePkg::creditT'(decodePkg::QUEUE_DEPTH);
        end
        else if (take_i && !return_i)
        begin
            count <= count - 1'b1;
        end
        else if (return_i && !take_i)
        begin
            count <= count + 1'b1;
        end
    end

    assign hasCredit_o = count != '0;

endmodule

`default_nettype wire

//--- instrDecoder.sv
`default_nettype none

module instrDecoder
(
    input  logic                    clk,
    input  logic                    rstN_i,
    input  logic                    fetchValid_i,
    input  decodePkg::instrT        instr_i,
    input  decodePkg::idTagT        id_i,
    input  decodePkg::regIdxT       destReg_i,
    input  logic                    predictTaken_i,
    input  logic                    creditReturn_i,
    output logic                    fetchReady_o,
    output logic                    decValid_o,
    output decodePkg::decodedInstrS decoded_o
);

    decodePkg::memInfoS     memInfo;
    decodePkg::unitInfoS    unitInfo;
    decodePkg::operandInfoS operandInfo;
    logic hasCredit;
    logic accept;

    // ========================================
    // Fetch handshake under queue credit
    // ========================================
    assign fetchReady_o = hasCredit;
    assign accept       = fetchValid_i && hasCredit;

    creditCounter i_creditCounter
    (
        .clk         (clk),
        .rstN_i      (rstN_i),
        .take_i      (accept),
        .return_i    (creditReturn_i),
        .hasCredit_o (hasCredit)
    );

    // Classifiers
    memClassify i_memClassify
    (
        .instr_i   (instr_i),
        .memInfo_o (memInfo)
    );

    unitClassify i_unitClassify
    (
        .instr_i        (instr_i),
        .predictTaken_i (predictTaken_i),
        .isMem_i        (memInfo.isMem),
        .unitInfo_o     (unitInfo)
    );

    operandDecode i_operandDecode
    (
        .instr_i       (instr_i),
        .destReg_i     (destReg_i),
        .isLoad_i      (memInfo.isLoad),
        .operandInfo_o (operandInfo)
    );

    // ========================================
    // Output register
    // ========================================
    always_ff @(posedge clk)
    begin
        if (!rstN_i)
            decValid_o <= 1'b0;
        else
            decValid_o <= accept;
    end

    // Record only changes on an accept
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            decoded_o.memInfo     <= memInfo;
            decoded_o.unitInfo    <= unitInfo;
            decoded_o.operandInfo <= operandInfo;
            decoded_o.id          <= id_i;
        end
    end

endmodule

`default_nettype wire

//--- instrDecoder_assert.sv
`default_nettype none

module instrDecoderAssert
(
    input wire logic             clk,
    input wire logic             rstN_i,
    input wire logic             fetchValid_i,
    input wire logic             fetchReady_o,
    input wire logic             decValid_o,
    input wire decodePkg::idTagT id_i,
    input wire decodePkg::idTagT decodedId
);

    // Valid exactly one cycle after an accept, with its tag
    acceptToValid: assert property (@(posedge clk) disable iff (!rstN_i)
        (fetchValid_i && fetchReady_o) |=> (decValid_o && decodedId == $past(id_i)))
        else $error("decValid_o or tag wrong after accept");

    noAcceptNoValid: assert property (@(posedge clk) disable iff (!rstN_i)
        !(fetchValid_i && fetchReady_o) |=> !decValid_o)
        else $error("decValid_o without accept");

    validLowAfterReset: assert property (@(posedge clk) !rstN_i |=> !decValid_o)
        else $error("decValid_o high after reset");

endmodule

bind instrDecoder instrDecoderAssert i_assert
(
    .clk          (clk),
    .rstN_i       (rstN_i),
    .fetchValid_i (fetchValid_i),
    .fetchReady_o (fetchReady_o),
    .decValid_o   (decValid_o),
    .id_i         (id_i),
    .decodedId    (decoded_o.id)
);

`default_nettype wire

//--- tb_instrDecoder.sv
`default_nettype none

module tb_instrDecoder;

    localparam int PERIOD = 40;
    // Instructions sent by credits, alu, mem, ctrl and regs tests
    localparam int INSTR_COUNT = 11 + 24 + 58 + 20 + 56;

    logic clk = 1'b0;
    logic rstN_i, fetchValid_i, predictTaken_i, creditReturn_i;
    decodePkg::instrT  instr_i;
    decodePkg::idTagT  id_i;
    decodePkg::regIdxT destReg_i;
    logic fetchReady_o, decValid_o;
    decodePkg::decodedInstrS decoded_o;
    int unsigned lcgState = 75;

    instrDecoder i_dut
    (
        .clk            (clk),
        .rstN_i         (rstN_i),
        .fetchValid_i   (fetchValid_i),
        .instr_i        (instr_i),
        .id_i           (id_i),
        .destReg_i      (destReg_i),
        .predictTaken_i (predictTaken_i),
        .creditReturn_i (creditReturn_i),
        .fetchReady_o   (fetchReady_o),
        .decValid_o     (decValid_o),
        .decoded_o      (decoded_o)
    );

    always #(PERIOD / 2) clk = !clk;

    function automatic int unsigned nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic decodePkg::instrT randInstr();
        logic [63:0] r;
        r = {nextRand(), nextRand()};
        return r[47:0];
    endfunction

    task automatic checkVal(input string name, input logic [127:0] exp, input logic [127:0] act);
        if (exp !== act)
        begin
            $display("error %s expected %h actual %h", name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // ========================================
    // Reference model from the decode rules
    // ========================================
    function automatic decodePkg::decodedInstrS expectDecode(input decodePkg::instrT ins,
        input decodePkg::regIdxT dest, input logic pred);
        decodePkg::decodedInstrS d;
        logic [5:0] op, fn;
        logic base, r2, ndx, fl, rti, ordered, wr;
        d = '0;
        op = ins[5:0];
        fn = ins[31:26];
        base = ins[7:6] == 2'b00;
        r2 = op == decodePkg::R2 && base;
        ndx = op == decodePkg::MEMNDX && base;
        fl = op == decodePkg::FLOAT && base;
        rti = r2 && fn == decodePkg::RTI;
        // Memory flags
        d.memInfo.isMem = op inside {decodePkg::LB, decodePkg::LX, decodePkg::SB,
            decodePkg::SX, decodePkg::CAS, decodePkg::AMO, decodePkg::MEMNDX};
        d.memInfo.isMemNdx = op == decodePkg::MEMNDX;
        d.memInfo.isLoad = op inside {decodePkg::LB, decodePkg::LX}
            || (ndx && fn inside {decodePkg::LBX, decodePkg::LWX, decodePkg::LWRX});
        d.memInfo.isVolatileLoad = ndx && fn == decodePkg::LWRX;
        d.memInfo.isStore = op inside {decodePkg::SB, decodePkg::SX, decodePkg::CAS,
            decodePkg::AMO} || (ndx && fn inside {decodePkg::SBX, decodePkg::SWX,
            decodePkg::SWCX, decodePkg::CASX});
        d.memInfo.isRmw = op inside {decodePkg::CAS, decodePkg::AMO}
            || (ndx && fn == decodePkg::CASX);
        if (op inside {decodePkg::LB, decodePkg::SB}
            || (ndx && fn inside {decodePkg::LBX, decodePkg::SBX}))
            d.memInfo.memSize = decodePkg::MEM_BYTE;
        else if (op inside {decodePkg::LX, decodePkg::SX} && ins[20:18] != 3'b100)
            d.memInfo.memSize = ins[19:18] == 2'b10 ? decodePkg::MEM_TETRA
                : (ins[18] ? decodePkg::MEM_WYDE : decodePkg::MEM_OCTA);
        else if (op == decodePkg::AMO && !ins[23])
            d.memInfo.memSize = ins[22:21];
        else
            d.memInfo.memSize = decodePkg::MEM_OCTA;
        ordered = op == decodePkg::AMO || (ndx && fn inside {decodePkg::LWRX, decodePkg::SWCX});
        d.memInfo.isAcquire = ordered && ins[25];
        d.memInfo.isRelease = ordered && ins[24];
        d.memInfo.isMemDb = r2 && fn == decodePkg::R1 && ins[22:18] == decodePkg::MEMDB;
        d.memInfo.isMemSb = r2 && fn == decodePkg::R1 && ins[22:18] == decodePkg::MEMSB;
        // Unit flags
        d.unitInfo.isFlowCtrl = rti || op inside {decodePkg::BRK, decodePkg::BCC,
            decodePkg::BEQI, decodePkg::JAL, decodePkg::JMP, decodePkg::CALL, decodePkg::RET};
        d.unitInfo.isAlu = !(d.unitInfo.isFlowCtrl || op == decodePkg::FLOAT);
        d.unitInfo.isAlu0 = (r2 && fn inside {decodePkg::R1, decodePkg::SHIFTR,
            decodePkg::MUL, decodePkg::DIVMOD})
            || op inside {decodePkg::MEMNDX, decodePkg::MULI, decodePkg::DIVI};
        d.unitInfo.isFpu = op == decodePkg::FLOAT;
        d.unitInfo.isBranch = op inside {decodePkg::BCC, decodePkg::BEQI};
        d.unitInfo.branchTaken = d.unitInfo.isBranch && pred;
        d.unitInfo.isJmp = op == decodePkg::JMP && !ins[7];
        d.unitInfo.isSync = rti || op == decodePkg::BRK
            || (r2 && fn == decodePkg::R1 && ins[22:18] == decodePkg::SYNC);
        d.unitInfo.isFSync = fl && fn == decodePkg::FSYNC;
        d.unitInfo.isOddball = rti || op inside {decodePkg::BRK, decodePkg::FLOAT};
        d.unitInfo.canExcept = (fl && fn == decodePkg::FADD) || d.memInfo.isMem
            || op inside {decodePkg::ADDI, decodePkg::MULI, decodePkg::DIVI,
            decodePkg::BCC, decodePkg::BEQI} || (r2 && fn inside {decodePkg::ADD,
            decodePkg::SUB, decodePkg::MUL, decodePkg::DIVMOD, decodePkg::RTI});
        // Operands
        d.operandInfo.len = base ? 3'd4 : (ins[7:6] == 2'b01 ? 3'd6 : 3'd2);
        d.operandInfo.constVal = ins[7:6] == 2'b01 ? 64'(signed'(ins[47:18]))
            : 64'(signed'(ins[31:18]));
        d.operandInfo.hasConst = op inside {decodePkg::ADDI, decodePkg::ANDI,
            decodePkg::ORI, decodePkg::MULI, decodePkg::DIVI, decodePkg::LB, decodePkg::LX,
            decodePkg::SB, decodePkg::SX, decodePkg::CAS, decodePkg::JAL, decodePkg::CALL,
            decodePkg::RET};
        wr = (r2 && fn inside {decodePkg::R1, decodePkg::ADD, decodePkg::SUB, decodePkg::AND,
            decodePkg::OR, decodePkg::MUL, decodePkg::DIVMOD, decodePkg::SHIFTR})
            || (ndx && fn inside {decodePkg::LBX, decodePkg::LWX, decodePkg::LWRX,
            decodePkg::CASX}) || op inside {decodePkg::ADDI, decodePkg::ANDI, decodePkg::ORI,
            decodePkg::MULI, decodePkg::DIVI, decodePkg::JAL, decodePkg::CALL, decodePkg::RET,
            decodePkg::LB, decodePkg::LX, decodePkg::CAS, decodePkg::AMO};
        d.operandInfo.regWrite = wr && dest != 0;
        d.operandInfo.preload = d.memInfo.isLoad && dest == 0;
        d.operandInfo.writeLanes = 8'hFF;
        if (r2 && fn inside {decodePkg::ADD, decodePkg::SUB, decodePkg::AND, decodePkg::OR,
            decodePkg::MUL, decodePkg::DIVMOD} && ins[25:23] < 3)
            d.operandInfo.writeLanes = ins[25:23] == 0 ? 8'h01 : (ins[24] ? 8'h0F : 8'h03);
        return d;
    endfunction

    // Send one instruction, wait for its record, return a credit
    task automatic decodeOne(input string name, input decodePkg::instrT ins,
        input decodePkg::regIdxT dest, input logic pred);
        decodePkg::decodedInstrS exp;
        @(negedge clk);
        fetchValid_i = 1'b1;
        instr_i = ins;
        destReg_i = dest;
        predictTaken_i = pred;
        id_i = id_i + 1'b1;
        while (!fetchReady_o)
            @(negedge clk);
        @(negedge clk);
        fetchValid_i = 1'b0;
        exp = expectDecode(ins, dest, pred);
        exp.id = id_i;
        checkVal({name, " valid"}, 1'b1, decValid_o);
        checkVal({name, " mem"}, exp.memInfo, decoded_o.memInfo);
        checkVal({name, " unit"}, exp.unitInfo, decoded_o.unitInfo);
        checkVal({name, " operand"}, exp.operandInfo, decoded_o.operandInfo);
        checkVal({name, " id"}, exp.id, decoded_o.id);
        creditReturn_i = 1'b1;
        @(negedge clk);
        creditReturn_i = 1'b0;
    endtask

    function automatic decodePkg::instrT withFunct(input logic [5:0] op, input logic [5:0] fn);
        decodePkg::instrT r;
        r = randInstr();
        return {r[47:32], fn, r[25:8], 2'b00, op};
    endfunction

    // ========================================
    // Directed tests
    // ========================================
    task automatic testAlu();
        logic [5:0] imm[5] = '{decodePkg::ADDI, decodePkg::ANDI, decodePkg::ORI,
            decodePkg::MULI, decodePkg::DIVI};
        logic [5:0] fns[9] = '{decodePkg::ADD, decodePkg::SUB, decodePkg::AND, decodePkg::OR,
            decodePkg::MUL, decodePkg::DIVMOD, decodePkg::SHIFTR, decodePkg::R1, decodePkg::RTI};
        decodePkg::instrT r;
        for (int i = 0; i < 5; i++)
            for (int len = 0; len < 3; len++)
            begin
                r = randInstr();
                decodeOne("alu imm", {r[47:8], 2'(len), imm[i]}, 5'd3, 1'b0);
            end
        foreach (fns[i])
            decodeOne("alu r2", withFunct(decodePkg::R2, fns[i]), 5'd7, 1'b0);
    endtask

    task automatic testMem();
        logic [5:0] ops[6] = '{decodePkg::LB, decodePkg::LX, decodePkg::SB, decodePkg::SX,
            decodePkg::CAS, decodePkg::AMO};
        logic [5:0] ndx[7] = '{decodePkg::LBX, decodePkg::LWX, decodePkg::LWRX,
            decodePkg::SBX, decodePkg::SWX, decodePkg::SWCX, decodePkg::CASX};
        decodePkg::instrT r;
        foreach (ops[i])
            decodeOne("mem", withFunct(ops[i], 6'(nextRand())), 5'd2, 1'b0);
        for (int s = 0; s < 8; s++)
        begin
            r = randInstr();
            decodeOne("mem lx size", {r[47:21], 3'(s), r[17:6], decodePkg::LX}, 5'd4, 1'b0);
            r = randInstr();
            decodeOne("mem sx size", {r[47:21], 3'(s), r[17:6], decodePkg::SX}, 5'd4, 1'b0);
            r = randInstr();
            decodeOne("mem amo", {r[47:24], 3'(s), r[20:6], decodePkg::AMO}, 5'd4, 1'b0);
        end
        foreach (ndx[i])
            for (int ord = 0; ord < 4; ord++)
            begin
                r = withFunct(decodePkg::MEMNDX, ndx[i]);
                r[25:24] = 2'(ord);
                decodeOne("mem ndx", r, 5'd9, 1'b0);
            end
    endtask

    task automatic testCtrl();
        logic [5:0] ops[7] = '{decodePkg::BRK, decodePkg::BCC, decodePkg::BEQI,
            decodePkg::JAL, decodePkg::JMP, decodePkg::CALL, decodePkg::RET};
        logic [4:0] subFns[3] = '{decodePkg::SYNC, decodePkg::MEMDB, decodePkg::MEMSB};
        decodePkg::instrT r;
        foreach (ops[i])
            for (int p = 0; p < 2; p++)
            begin
                r = randInstr();
                r[7] = p[0];
                decodeOne("ctrl", {r[47:6], ops[i]}, 5'd1, p[0]);
            end
        decodeOne("ctrl rti", withFunct(decodePkg::R2, decodePkg::RTI), 5'd1, 1'b1);
        foreach (subFns[i])
        begin
            r = withFunct(decodePkg::R2, decodePkg::R1);
            r[22:18] = subFns[i];
            decodeOne("ctrl r1", r, 5'd1, 1'b0);
        end
        decodeOne("ctrl fadd", withFunct(decodePkg::FLOAT, decodePkg::FADD), 5'd1, 1'b0);
        decodeOne("ctrl fsync", withFunct(decodePkg::FLOAT, decodePkg::FSYNC), 5'd1, 1'b0);
    endtask

    task automatic testRegs();
        logic [5:0] fns[6] = '{decodePkg::ADD, decodePkg::SUB, decodePkg::AND, decodePkg::OR,
            decodePkg::MUL, decodePkg::DIVMOD};
        decodePkg::instrT r;
        for (int d = 0; d < 2; d++)
        begin
            decodeOne("regs lb", withFunct(decodePkg::LB, 6'd0), 5'(d * 11), 1'b0);
            decodeOne("regs lwx", withFunct(decodePkg::MEMNDX, decodePkg::LWX), 5'(d * 5), 1'b0);
            decodeOne("regs sx", withFunct(decodePkg::SX, 6'd3), 5'(d * 6), 1'b0);
            decodeOne("regs addi", withFunct(decodePkg::ADDI, 6'd9), 5'(d * 31), 1'b0);
        end
        foreach (fns[i])
            for (int l = 0; l < 8; l++)
            begin
                r = withFunct(decodePkg::R2, fns[i]);
                r[25:23] = 3'(l);
                decodeOne("regs lanes", r, 5'd8, 1'b0);
            end
    endtask

    task automatic testCredits();
        decodePkg::idTagT base;
        base = id_i + 1'b1;
        checkVal("credits ready", 1'b1, fetchReady_o);
        for (int i = 0; i <= decodePkg::QUEUE_DEPTH; i++)
        begin
            @(negedge clk);
            if (i > 0)
                checkVal("credits tag", {1'b1, 5'(base + i - 1)}, {decValid_o, decoded_o.id});
            fetchValid_i = 1'b1;
            instr_i = randInstr();
            id_i = 5'(base + i);
        end
        checkVal("credits full", 1'b0, fetchReady_o);
        @(negedge clk);
        checkVal("credits held", 2'b00, {fetchReady_o, decValid_o});
        creditReturn_i = 1'b1;
        @(negedge clk);
        creditReturn_i = 1'b0;
        checkVal("credits return", 2'b10, {fetchReady_o, decValid_o});
        @(negedge clk);
        fetchValid_i = 1'b0;
        checkVal("credits late tag", {1'b1, 5'(base + 4)}, {decValid_o, decoded_o.id});
        checkVal("credits empty", 1'b0, fetchReady_o);
        creditReturn_i = 1'b1;
        repeat (2)
            @(negedge clk);
        // Accept and return on the same edge, count stays at two
        for (int i = 5; i < 12; i++)
        begin
            if (i > 5)
                checkVal("credits burst tag", {1'b1, 5'(base + i - 1)}, {decValid_o, decoded_o.id});
            checkVal("credits burst ready", 1'b1, fetchReady_o);
            fetchValid_i = i < 11;
            instr_i = randInstr();
            id_i = 5'(base + i);
            @(negedge clk);
        end
        creditReturn_i = 1'b0;
        id_i = 5'(base + 10);
        checkVal("credits restored", 1'b1, fetchReady_o);
    endtask

    initial
    begin
        #(PERIOD * (8 + 40 * INSTR_COUNT));
        $display("Timeout, decoder did not finish all tests in time");
        $display("Test failed");
        $fatal(1);
    end

    initial
    begin
        rstN_i = 1'b0;
        fetchValid_i = 1'b0;
        predictTaken_i = 1'b0;
        creditReturn_i = 1'b0;
        instr_i = '0;
        id_i = '0;
        destReg_i = '0;
        repeat (8)
            @(negedge clk);
        rstN_i = 1'b1;
        testCredits();
        testAlu();
        testMem();
        testCtrl();
        testRegs();
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
decodePkg.sv
memClassify.sv
unitClassify.sv
operandDecode.sv
creditCounter.sv
instrDecoder.sv
instrDecoder_assert.sv
tb_instrDecoder.sv
